/* bench/serial_link_tb.sv */
/*
  Testbench for the serial link data layer. Loops the phy channels back
  through a two-stage delay and runs a table of normal and raw-mode tests.
*/
`include "serial_link_params.svh"

module serial_link_tb;

  localparam int BeatWidth  = `SL_NUM_CHANNELS * `SL_CHAN_BITS;
  localparam int Splits     = `SL_PAYLOAD_BITS / BeatWidth;
  localparam int RecvDepth  = `SL_RECV_DEPTH;
  localparam int FifoDepth  = `SL_RAW_FIFO_DEPTH;
  localparam int BurstLen   = 3;
  localparam int HoldCycles = 40;
  localparam int WaitLimit  = 400;
  localparam int NumEntries = 8;

  localparam logic [1:0] ModeNormal = 2'd0;
  localparam logic [1:0] ModeRaw    = 2'd1;
  localparam logic [1:0] ModeFill   = 2'd2;
  localparam logic [1:0] BpNone     = 2'd0;
  localparam logic [1:0] BpRandom   = 2'd1;
  localparam logic [1:0] BpHold     = 2'd2;

  typedef struct packed {
    logic [1:0]                  mode;
    serial_link_pkg::payload_t   data;
    serial_link_pkg::ch_mask_t   mask;
    serial_link_pkg::ch_sel_t    sel;
    logic [1:0]                  bp;
  } entry_t;

  logic                        clk = 1'b0;
  logic                        rst_n = 1'b0;
  serial_link_pkg::payload_t   in_data, out_data;
  logic                        in_valid, in_ready, out_valid, out_ready;
  serial_link_pkg::beat_t      tx_data;
  serial_link_pkg::beat_t      tx_data_s1 = '0;
  serial_link_pkg::beat_t      rx_data = '0;
  serial_link_pkg::ch_mask_t   tx_valid;
  serial_link_pkg::ch_mask_t   tx_valid_s1 = '0;
  serial_link_pkg::ch_mask_t   rx_valid = '0;
  logic                        credit_out;
  logic                        credit_s1 = 1'b0;
  logic                        credit_in = 1'b0;
  logic                        cfg_we, cfg_re;
  serial_link_pkg::cfg_addr_e  cfg_addr;
  logic [15:0]                 cfg_wdata, cfg_rdata;

  entry_t                      table_q [NumEntries];
  serial_link_pkg::payload_t   burst [BurstLen];
  serial_link_pkg::payload_t   expect_q [$];
  integer                      seed = 19;
  int                          errors = 0;
  int                          checks = 0;
  int                          stall_beats = 0;

  always #4 clk = ~clk;

  serial_link_top UUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .pl_in_data_i   (in_data),
    .pl_in_valid_i  (in_valid),
    .pl_in_ready_o  (in_ready),
    .pl_out_data_o  (out_data),
    .pl_out_valid_o (out_valid),
    .pl_out_ready_i (out_ready),
    .phy_tx_data_o  (tx_data),
    .phy_tx_valid_o (tx_valid),
    .phy_credit_i   (credit_in),
    .phy_rx_data_i  (rx_data),
    .phy_rx_valid_i (rx_valid),
    .phy_credit_o   (credit_out),
    .cfg_we_i       (cfg_we),
    .cfg_re_i       (cfg_re),
    .cfg_addr_i     (cfg_addr),
    .cfg_wdata_i    (cfg_wdata),
    .cfg_rdata_o    (cfg_rdata)
  );

  // Loopback phy with two cycles each way
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_data_s1  <= '0;
      tx_valid_s1 <= '0;
      rx_data     <= '0;
      rx_valid    <= '0;
      credit_s1   <= 1'b0;
      credit_in   <= 1'b0;
    end else begin
      tx_data_s1  <= tx_data;
      tx_valid_s1 <= tx_valid;
      rx_data     <= #1 tx_data_s1;
      rx_valid    <= #1 tx_valid_s1;
      credit_s1   <= credit_out;
      credit_in   <= #1 credit_s1;
    end
  end

  // Full beats that leave while the consumer blocks the output
  always @(negedge clk) begin
    if (out_valid && !out_ready && (&tx_valid)) stall_beats = stall_beats + 1;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_payload(input string name, input serial_link_pkg::payload_t got,
                               input serial_link_pkg::payload_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_beat(input string name, input serial_link_pkg::beat_t got,
                            input serial_link_pkg::beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_chan(input string name, input serial_link_pkg::chan_data_t got,
                            input serial_link_pkg::chan_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input serial_link_pkg::ch_mask_t got,
                            input serial_link_pkg::ch_mask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_credits(input string name, input serial_link_pkg::credit_t got,
                               input serial_link_pkg::credit_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Bus helpers
  ////////////////////////////////////////

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s at t=%0t", what, $time);
    $display("test failed");
    $finish;
  endtask

  task automatic cfg_write(input serial_link_pkg::cfg_addr_e addr, input logic [15:0] data);
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_we    = 1'b1;
    tick();
    cfg_we    = 1'b0;
  endtask

  // Read data is combinational and a pop lands on the next edge
  task automatic cfg_read(input serial_link_pkg::cfg_addr_e addr, input logic pop,
                          output logic [15:0] data);
    cfg_addr = addr;
    cfg_re   = pop;
    #1;
    data = cfg_rdata;
    tick();
    cfg_re = 1'b0;
  endtask

  ////////////////////////////////////////
  // Payload traffic
  ////////////////////////////////////////

  task automatic send_burst();
    int i, k, waited;
    logic done;
    for (i = 0; i < BurstLen; i++) begin
      in_data  = burst[i];
      in_valid = 1'b1;
      k        = 0;
      waited   = 0;
      done     = 1'b0;
      while (!done) begin
        if (&tx_valid) begin
          check_beat("phy_tx_data_o", tx_data, BeatWidth'(burst[i] >> (k * BeatWidth)));
          k++;
        end
        if (in_ready) begin
          done = 1'b1;
          checks++;
          if (k != Splits) begin
            errors++;
            $display("payload %0d released after %0d beats instead of %0d", i, k, Splits);
          end
        end else begin
          waited++;
          if (waited == WaitLimit) stop_on_timeout("pl_in_ready_o");
        end
        tick();
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic receive_burst(input logic [1:0] bp);
    int got_n, waited, held;
    integer rnd;
    got_n  = 0;
    waited = 0;
    held   = 0;
    while (got_n < BurstLen) begin
      case (bp)
        BpNone: out_ready = 1'b1;
        BpRandom: begin
          rnd       = $random(seed);
          out_ready = rnd[0];
        end
        default: out_ready = (held >= HoldCycles);
      endcase
      held++;
      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          errors++;
          $display("payload arrived at t=%0t with none outstanding", $time);
        end else begin
          check_payload("pl_out_data_o", out_data, expect_q.pop_front());
        end
        got_n++;
        waited = 0;
      end else begin
        waited++;
        if (waited == WaitLimit) stop_on_timeout("pl_out_valid_o");
      end
      tick();
    end
    out_ready = 1'b0;
  endtask

  task automatic run_normal(input serial_link_pkg::payload_t first, input logic [1:0] bp);
    logic [15:0] rd;
    int i, stall_start, waited;
    burst[0] = first;
    for (i = 1; i < BurstLen; i++) burst[i] = {$random(seed), $random(seed)};
    for (i = 0; i < BurstLen; i++) expect_q.push_back(burst[i]);
    stall_start = stall_beats;
    fork
      send_burst();
      receive_burst(bp);
    join
    if (bp == BpHold) begin
      checks++;
      if (stall_beats - stall_start > RecvDepth) begin
        errors++;
        $display("%0d beats sent while the output was blocked, buffer holds only %0d",
                 stall_beats - stall_start, RecvDepth);
      end
    end
    // Let the last credits travel home
    waited = 0;
    cfg_read(serial_link_pkg::CfgStatus, 1'b0, rd);
    while (rd[7:4] != 4'(RecvDepth) && waited < 32) begin
      waited++;
      cfg_read(serial_link_pkg::CfgStatus, 1'b0, rd);
    end
    check_credits("CfgStatus credits", serial_link_pkg::credit_t'(rd[7:4]),
                  serial_link_pkg::credit_t'(RecvDepth));
  endtask

  ////////////////////////////////////////
  // Raw mode
  ////////////////////////////////////////

  task automatic run_raw(input serial_link_pkg::chan_data_t word,
                         input serial_link_pkg::ch_mask_t mask,
                         input serial_link_pkg::ch_sel_t sel);
    logic [15:0] rd;
    int c, waited;
    cfg_write(serial_link_pkg::CfgCtrl, 16'h0003 | (16'(sel) << 3) | (16'(mask) << 4));
    cfg_write(serial_link_pkg::CfgRawOut, 16'(word));
    waited = 0;
    while (tx_valid == '0) begin
      waited++;
      if (waited == WaitLimit) stop_on_timeout("raw word on phy_tx_valid_o");
      tick();
    end
    check_mask("phy_tx_valid_o", tx_valid, mask);
    for (c = 0; c < `SL_NUM_CHANNELS; c++) begin
      check_chan($sformatf("phy_tx_data_o[%0d]", c), tx_data[c], word);
    end
    waited = 0;
    cfg_read(serial_link_pkg::CfgRawIn, 1'b0, rd);
    while (!rd[8]) begin
      waited++;
      if (waited == WaitLimit) stop_on_timeout("raw capture valid");
      cfg_read(serial_link_pkg::CfgRawIn, 1'b0, rd);
    end
    cfg_read(serial_link_pkg::CfgRawIn, 1'b1, rd);
    check_flag("CfgRawIn valid", rd[8], 1'b1);
    check_chan("CfgRawIn data", rd[7:0], word);
    // Capture is gone after the pop
    cfg_read(serial_link_pkg::CfgRawIn, 1'b1, rd);
    check_flag("CfgRawIn valid", rd[8], 1'b0);
    cfg_write(serial_link_pkg::CfgCtrl, 16'h0000);
  endtask

  task automatic run_fill();
    logic [15:0] rd;
    int i;
    cfg_write(serial_link_pkg::CfgCtrl, 16'h0001);
    for (i = 0; i < FifoDepth + 2; i++) cfg_write(serial_link_pkg::CfgRawOut, 16'(i * 17 + 3));
    cfg_read(serial_link_pkg::CfgStatus, 1'b0, rd);
    check_reg("CfgStatus fill", 16'(rd[2:0]), 16'(FifoDepth));
    check_flag("CfgStatus full", rd[3], 1'b1);
    cfg_write(serial_link_pkg::CfgCtrl, 16'h0005);
    cfg_read(serial_link_pkg::CfgStatus, 1'b0, rd);
    check_reg("CfgStatus fill", 16'(rd[2:0]), 16'h0000);
    check_flag("CfgStatus full", rd[3], 1'b0);
    cfg_read(serial_link_pkg::CfgCtrl, 1'b0, rd);
    check_reg("CfgCtrl", rd, 16'h0001);
    cfg_write(serial_link_pkg::CfgCtrl, 16'h0000);
  endtask

  ////////////////////////////////////////
  // Stimulus table and main sequence
  ////////////////////////////////////////

  task automatic load_table();
    table_q[0] = '{ModeNormal, 64'h0706_0504_0302_0100, 2'b00, 1'b0, BpNone};
    table_q[1] = '{ModeNormal, 64'hdead_beef_cafe_f00d, 2'b00, 1'b0, BpRandom};
    table_q[2] = '{ModeNormal, 64'h0123_4567_89ab_cdef, 2'b00, 1'b0, BpHold};
    table_q[3] = '{ModeRaw,    64'h5a,                  2'b11, 1'b0, BpNone};
    table_q[4] = '{ModeRaw,    64'hc3,                  2'b10, 1'b1, BpNone};
    table_q[5] = '{ModeFill,   64'h0,                   2'b00, 1'b0, BpNone};
    table_q[6] = '{ModeNormal, 64'hffff_0000_aaaa_5555, 2'b00, 1'b0, BpRandom};
    table_q[7] = '{ModeRaw,    64'h81,                  2'b01, 1'b0, BpNone};
  endtask

  function automatic string mode_name(input logic [1:0] mode);
    case (mode)
      ModeNormal: return "normal";
      ModeRaw:    return "raw loopback";
      default:    return "raw FIFO fill";
    endcase
  endfunction

  initial begin
    logic [15:0] rd;
    int e, start_err;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    cfg_we    = 1'b0;
    cfg_re    = 1'b0;
    cfg_addr  = serial_link_pkg::CfgCtrl;
    cfg_wdata = '0;
    load_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_err = errors;
    check_flag("pl_in_ready_o", in_ready, 1'b0);
    check_flag("pl_out_valid_o", out_valid, 1'b0);
    check_mask("phy_tx_valid_o", tx_valid, '0);
    check_flag("phy_credit_o", credit_out, 1'b0);
    cfg_read(serial_link_pkg::CfgCtrl, 1'b0, rd);
    check_reg("CfgCtrl", rd, 16'h0000);
    $display("test 0 reset: %0d errors", errors - start_err);

    for (e = 0; e < NumEntries; e++) begin
      start_err = errors;
      case (table_q[e].mode)
        ModeNormal: run_normal(table_q[e].data, table_q[e].bp);
        ModeRaw:    run_raw(table_q[e].data[7:0], table_q[e].mask, table_q[e].sel);
        default:    run_fill();
      endcase
      $display("test %0d %s: %0d errors", e + 1, mode_name(table_q[e].mode),
               errors - start_err);
    end

    $display("tests %0d, checks %0d, errors %0d", NumEntries + 1, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* design/serial_link_cfg_regs.sv */
/*
  Register block of the serial link: raw-mode control, raw transmit FIFO
  and the read port for the raw receive capture. Reads decode combinationally.
*/
`include "serial_link_params.svh"

module serial_link_cfg_regs (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        cfg_we_i,
  input  logic                        cfg_re_i,
  input  serial_link_pkg::cfg_addr_e  cfg_addr_i,
  input  logic [15:0]                 cfg_wdata_i,
  output logic [15:0]                 cfg_rdata_o,
  output logic                        raw_en_o,
  output logic                        raw_out_en_o,
  output serial_link_pkg::ch_mask_t   raw_out_mask_o,
  output serial_link_pkg::ch_sel_t    raw_in_sel_o,
  output serial_link_pkg::chan_data_t raw_out_data_o,
  output logic                        raw_out_valid_o,
  input  logic                        raw_out_pop_i,
  input  serial_link_pkg::chan_data_t raw_in_data_i,
  input  logic                        raw_in_valid_i,
  output logic                        raw_in_pop_o,
  input  serial_link_pkg::credit_t    tx_credits_i
);

  localparam int Depth    = `SL_RAW_FIFO_DEPTH;
  localparam int PtrBits  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int FillBits = $clog2(Depth + 1);

  logic                        raw_en_q, raw_out_en_q;
  serial_link_pkg::ch_sel_t    raw_in_sel_q;
  serial_link_pkg::ch_mask_t   raw_out_mask_q;
  serial_link_pkg::chan_data_t fifo_mem [Depth];
  logic [PtrBits-1:0]          wr_ptr_q, rd_ptr_q;
  logic [FillBits-1:0]         fill_q;
  logic                        ctrl_we, fifo_clr, fifo_push, fifo_full;

  function automatic logic [PtrBits-1:0] ptr_next(input logic [PtrBits-1:0] ptr);
    return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ctrl_we   = cfg_we_i && (cfg_addr_i == serial_link_pkg::CfgCtrl);
  // Clear bit acts on the write itself and never reads back
  assign fifo_clr  = ctrl_we && cfg_wdata_i[2];
  assign fifo_full = (fill_q == FillBits'(Depth));
  assign fifo_push = cfg_we_i && (cfg_addr_i == serial_link_pkg::CfgRawOut) && !fifo_full;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      raw_en_q       <= 1'b0;
      raw_out_en_q   <= 1'b0;
      raw_in_sel_q   <= '0;
      raw_out_mask_q <= '0;
    end else if (ctrl_we) begin
      raw_en_q       <= cfg_wdata_i[0];
      raw_out_en_q   <= cfg_wdata_i[1];
      raw_in_sel_q   <= cfg_wdata_i[3 +: serial_link_pkg::ChSelBits];
      raw_out_mask_q <= cfg_wdata_i[4 +: `SL_NUM_CHANNELS];
    end
  end

  ////////////////////////////////////////
  // Raw transmit FIFO
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= cfg_wdata_i[`SL_CHAN_BITS-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else if (fifo_clr) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (fifo_push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (raw_out_pop_i) rd_ptr_q <= ptr_next(rd_ptr_q);
      if (fifo_push && !raw_out_pop_i) begin
        fill_q <= fill_q + 1'b1;
      end else if (!fifo_push && raw_out_pop_i) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  assign raw_out_data_o  = fifo_mem[rd_ptr_q];
  assign raw_out_valid_o = (fill_q != '0);

  ////////////////////////////////////////
  // Register read decode
  ////////////////////////////////////////

  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      serial_link_pkg::CfgCtrl: begin
        cfg_rdata_o[0] = raw_en_q;
        cfg_rdata_o[1] = raw_out_en_q;
        cfg_rdata_o[3 +: serial_link_pkg::ChSelBits] = raw_in_sel_q;
        cfg_rdata_o[4 +: `SL_NUM_CHANNELS] = raw_out_mask_q;
      end
      serial_link_pkg::CfgRawIn: begin
        cfg_rdata_o[`SL_CHAN_BITS-1:0] = raw_in_data_i;
        cfg_rdata_o[8] = raw_in_valid_i;
      end
      serial_link_pkg::CfgStatus: begin
        cfg_rdata_o[0 +: FillBits] = fill_q;
        cfg_rdata_o[3] = fifo_full;
        cfg_rdata_o[4 +: serial_link_pkg::CreditBits] = tx_credits_i;
      end
      // Raw out is write only
      default: cfg_rdata_o = '0;
    endcase
  end

  assign raw_in_pop_o   = cfg_re_i && (cfg_addr_i == serial_link_pkg::CfgRawIn);
  assign raw_en_o       = raw_en_q;
  assign raw_out_en_o   = raw_out_en_q;
  assign raw_out_mask_o = raw_out_mask_q;
  assign raw_in_sel_o   = raw_in_sel_q;

  // The transmit link only pops what the FIFO offers
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    raw_out_pop_i |-> raw_out_valid_o)
    else $error("raw FIFO popped while empty");

endmodule

/* design/serial_link_params.svh */
/*
  Build-time sizing of the serial link data layer.
  Included by the package and by every module that sizes storage from it.
*/
`ifndef SERIAL_LINK_PARAMS_SVH
`define SERIAL_LINK_PARAMS_SVH

// Parallel phy channels
`define SL_NUM_CHANNELS 2

// Bits per channel per beat
`define SL_CHAN_BITS 8

// Payload width, a whole number of beats
`define SL_PAYLOAD_BITS 64

// Receive buffer slots, also the credits granted at reset
`define SL_RECV_DEPTH 4

// Words held by the raw transmit FIFO
`define SL_RAW_FIFO_DEPTH 4

`endif

/* design/serial_link_pkg.sv */
/*
  Types shared by the serial link RTL and its testbench.
  Refer to them by scoped name, serial_link_pkg::beat_t and so on.
*/
`include "serial_link_params.svh"

package serial_link_pkg;

  localparam int BeatBits   = `SL_NUM_CHANNELS * `SL_CHAN_BITS;
  localparam int NumSplits  = `SL_PAYLOAD_BITS / BeatBits;
  localparam int ChSelBits  = (`SL_NUM_CHANNELS > 1) ? $clog2(`SL_NUM_CHANNELS) : 1;
  localparam int CreditBits = $clog2(`SL_RECV_DEPTH + 1);

  typedef logic [`SL_CHAN_BITS-1:0] chan_data_t;
  // Channel 0 sits in the low bits
  typedef chan_data_t [`SL_NUM_CHANNELS-1:0] beat_t;
  // Beat 0 sits in the low bits
  typedef logic [`SL_PAYLOAD_BITS-1:0] payload_t;
  typedef logic [`SL_NUM_CHANNELS-1:0] ch_mask_t;
  typedef logic [ChSelBits-1:0] ch_sel_t;
  typedef logic [CreditBits-1:0] credit_t;

  typedef enum logic [1:0] {
    CfgCtrl   = 2'd0,
    CfgRawOut = 2'd1,
    CfgRawIn  = 2'd2,
    CfgStatus = 2'd3
  } cfg_addr_e;

  typedef enum logic {TxIdle, TxBusy} tx_state_e;

endpackage

/* design/serial_link_rx.sv */
/*
  Receive data link. Buffers beats from the phy, reassembles payloads,
  returns one credit per beat drained, and captures raw words on one channel.
*/
`include "serial_link_params.svh"

module serial_link_rx (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  serial_link_pkg::beat_t      phy_rx_data_i,
  input  serial_link_pkg::ch_mask_t   phy_rx_valid_i,
  output logic                        phy_credit_o,
  output serial_link_pkg::payload_t   pl_out_data_o,
  output logic                        pl_out_valid_o,
  input  logic                        pl_out_ready_i,
  input  logic                        raw_en_i,
  input  serial_link_pkg::ch_sel_t    raw_in_sel_i,
  output serial_link_pkg::chan_data_t raw_in_data_o,
  output logic                        raw_in_valid_o,
  input  logic                        raw_in_pop_i
);

  localparam int Depth    = `SL_RECV_DEPTH;
  localparam int PtrBits  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntBits  = $clog2(Depth + 1);
  localparam int BeatBits = serial_link_pkg::BeatBits;
  localparam int Splits   = serial_link_pkg::NumSplits;
  localparam int IdxBits  = (Splits > 1) ? $clog2(Splits) : 1;

  serial_link_pkg::beat_t      buf_mem [Depth];
  logic [PtrBits-1:0]          wr_ptr_q, rd_ptr_q;
  logic [CntBits-1:0]          count_q;
  logic                        buf_push, buf_pop, buf_full;
  serial_link_pkg::payload_t   asm_q;
  logic [IdxBits-1:0]          split_idx_q;
  logic                        out_valid_q, credit_q;
  serial_link_pkg::chan_data_t raw_q;
  logic                        raw_valid_q;

  function automatic logic [PtrBits-1:0] ptr_next(input logic [PtrBits-1:0] ptr);
    return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Beat buffer
  ////////////////////////////////////////

  // Only a beat with every channel valid counts
  assign buf_push = !raw_en_i && (&phy_rx_valid_i);
  assign buf_full = (count_q == CntBits'(Depth));
  // Drain while the assembler has room or is handing off this cycle
  assign buf_pop  = !raw_en_i && (count_q != '0) && (!out_valid_q || pl_out_ready_i);

  always_ff @(posedge clk_i) begin
    if (buf_push) begin
      buf_mem[wr_ptr_q] <= phy_rx_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (buf_push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (buf_pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      if (buf_push && !buf_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!buf_push && buf_pop) begin
        count_q <= count_q - 1'b1;
      end
      // One credit per freed slot
      credit_q <= buf_pop;
    end
  end

  assign phy_credit_o = credit_q;

  ////////////////////////////////////////
  // Payload assembly
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (buf_pop) begin
      asm_q[split_idx_q*BeatBits +: BeatBits] <= buf_mem[rd_ptr_q];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      split_idx_q <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (out_valid_q && pl_out_ready_i) out_valid_q <= 1'b0;
      if (buf_pop) begin
        if (split_idx_q == IdxBits'(Splits - 1)) begin
          split_idx_q <= '0;
          out_valid_q <= 1'b1;
        end else begin
          split_idx_q <= split_idx_q + 1'b1;
        end
      end
    end
  end

  assign pl_out_data_o  = asm_q;
  assign pl_out_valid_o = out_valid_q;

  ////////////////////////////////////////
  // Raw capture
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (raw_en_i && phy_rx_valid_i[raw_in_sel_i]) begin
      raw_q <= phy_rx_data_i[raw_in_sel_i];
    end
  end

  // A new word wins over a pop in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      raw_valid_q <= 1'b0;
    end else if (raw_en_i && phy_rx_valid_i[raw_in_sel_i]) begin
      raw_valid_q <= 1'b1;
    end else if (raw_in_pop_i) begin
      raw_valid_q <= 1'b0;
    end
  end

  assign raw_in_data_o  = raw_q;
  assign raw_in_valid_o = raw_valid_q;

  // Credits at the far end keep the buffer from overflowing
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    buf_push |-> !buf_full)
    else $error("receive buffer pushed while full");

endmodule

/* design/serial_link_top.sv */
/*
  Serial link data layer top. Register block sits beside the transmit and
  receive links; phy channels are left as ports for the physical layer.
*/
module serial_link_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  serial_link_pkg::payload_t  pl_in_data_i,
  input  logic                       pl_in_valid_i,
  output logic                       pl_in_ready_o,
  output serial_link_pkg::payload_t  pl_out_data_o,
  output logic                       pl_out_valid_o,
  input  logic                       pl_out_ready_i,
  output serial_link_pkg::beat_t     phy_tx_data_o,
  output serial_link_pkg::ch_mask_t  phy_tx_valid_o,
  input  logic                       phy_credit_i,
  input  serial_link_pkg::beat_t     phy_rx_data_i,
  input  serial_link_pkg::ch_mask_t  phy_rx_valid_i,
  output logic                       phy_credit_o,
  input  logic                       cfg_we_i,
  input  logic                       cfg_re_i,
  input  serial_link_pkg::cfg_addr_e cfg_addr_i,
  input  logic [15:0]                cfg_wdata_i,
  output logic [15:0]                cfg_rdata_o
);

  logic                        raw_en, raw_out_en, raw_out_valid, raw_out_pop;
  logic                        raw_in_valid, raw_in_pop;
  serial_link_pkg::ch_mask_t   raw_out_mask;
  serial_link_pkg::ch_sel_t    raw_in_sel;
  serial_link_pkg::chan_data_t raw_out_data, raw_in_data;
  serial_link_pkg::credit_t    tx_credits;

  serial_link_cfg_regs i_cfg_regs (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_we_i        (cfg_we_i),
    .cfg_re_i        (cfg_re_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .cfg_rdata_o     (cfg_rdata_o),
    .raw_en_o        (raw_en),
    .raw_out_en_o    (raw_out_en),
    .raw_out_mask_o  (raw_out_mask),
    .raw_in_sel_o    (raw_in_sel),
    .raw_out_data_o  (raw_out_data),
    .raw_out_valid_o (raw_out_valid),
    .raw_out_pop_i   (raw_out_pop),
    .raw_in_data_i   (raw_in_data),
    .raw_in_valid_i  (raw_in_valid),
    .raw_in_pop_o    (raw_in_pop),
    .tx_credits_i    (tx_credits)
  );

  serial_link_tx i_tx (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .pl_in_data_i    (pl_in_data_i),
    .pl_in_valid_i   (pl_in_valid_i),
    .pl_in_ready_o   (pl_in_ready_o),
    .phy_tx_data_o   (phy_tx_data_o),
    .phy_tx_valid_o  (phy_tx_valid_o),
    .phy_credit_i    (phy_credit_i),
    .raw_en_i        (raw_en),
    .raw_out_en_i    (raw_out_en),
    .raw_out_mask_i  (raw_out_mask),
    .raw_out_data_i  (raw_out_data),
    .raw_out_valid_i (raw_out_valid),
    .raw_out_pop_o   (raw_out_pop),
    .credits_o       (tx_credits)
  );

  serial_link_rx i_rx (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .phy_rx_data_i  (phy_rx_data_i),
    .phy_rx_valid_i (phy_rx_valid_i),
    .phy_credit_o   (phy_credit_o),
    .pl_out_data_o  (pl_out_data_o),
    .pl_out_valid_o (pl_out_valid_o),
    .pl_out_ready_i (pl_out_ready_i),
    .raw_en_i       (raw_en),
    .raw_in_sel_i   (raw_in_sel),
    .raw_in_data_o  (raw_in_data),
    .raw_in_valid_o (raw_in_valid),
    .raw_in_pop_i   (raw_in_pop)
  );

endmodule

/* design/serial_link_tx.sv */
/*
  Transmit data link. Splits each payload into beats over the phy channels,
  one beat per credit, and in raw mode sends raw FIFO words under a mask.
*/
`include "serial_link_params.svh"

module serial_link_tx (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  serial_link_pkg::payload_t   pl_in_data_i,
  input  logic                        pl_in_valid_i,
  output logic                        pl_in_ready_o,
  output serial_link_pkg::beat_t      phy_tx_data_o,
  output serial_link_pkg::ch_mask_t   phy_tx_valid_o,
  input  logic                        phy_credit_i,
  input  logic                        raw_en_i,
  input  logic                        raw_out_en_i,
  input  serial_link_pkg::ch_mask_t   raw_out_mask_i,
  input  serial_link_pkg::chan_data_t raw_out_data_i,
  input  logic                        raw_out_valid_i,
  output logic                        raw_out_pop_o,
  output serial_link_pkg::credit_t    credits_o
);

  localparam int BeatBits = serial_link_pkg::BeatBits;
  localparam int Splits   = serial_link_pkg::NumSplits;
  localparam int IdxBits  = (Splits > 1) ? $clog2(Splits) : 1;

  serial_link_pkg::tx_state_e state_q, state_d;
  logic [IdxBits-1:0]         beat_idx_q, beat_idx_d;
  serial_link_pkg::credit_t   credit_q;
  logic                       beat_sent;

  ////////////////////////////////////////
  // Beat sequencing
  ////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    beat_idx_d     = beat_idx_q;
    pl_in_ready_o  = 1'b0;
    phy_tx_data_o  = '0;
    phy_tx_valid_o = '0;
    raw_out_pop_o  = 1'b0;
    beat_sent      = 1'b0;

    if (raw_en_i) begin
      // Same word on every channel, the mask picks who sees it
      if (raw_out_en_i && raw_out_valid_i) begin
        phy_tx_data_o  = {`SL_NUM_CHANNELS{raw_out_data_i}};
        phy_tx_valid_o = raw_out_mask_i;
        raw_out_pop_o  = 1'b1;
      end
    end else begin
      unique case (state_q)
        serial_link_pkg::TxIdle: begin
          if (pl_in_valid_i) begin
            state_d    = serial_link_pkg::TxBusy;
            beat_idx_d = '0;
          end
        end
        serial_link_pkg::TxBusy: begin
          phy_tx_data_o = pl_in_data_i[beat_idx_q*BeatBits +: BeatBits];
          if (credit_q != '0) begin
            phy_tx_valid_o = '1;
            beat_sent      = 1'b1;
            if (beat_idx_q == IdxBits'(Splits - 1)) begin
              // Last beat out, release the payload
              pl_in_ready_o = 1'b1;
              state_d       = serial_link_pkg::TxIdle;
              beat_idx_d    = '0;
            end else begin
              beat_idx_d = beat_idx_q + 1'b1;
            end
          end
        end
        default: state_d = serial_link_pkg::TxIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= serial_link_pkg::TxIdle;
      beat_idx_q <= '0;
    end else begin
      state_q    <= state_d;
      beat_idx_q <= beat_idx_d;
    end
  end

  ////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////

  // Spend and return may land in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= serial_link_pkg::credit_t'(`SL_RECV_DEPTH);
    end else if (beat_sent && !phy_credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (!beat_sent && phy_credit_i) begin
      credit_q <= credit_q + 1'b1;
    end
  end

  assign credits_o = credit_q;

  // Receiver never returns more slots than it has
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_q <= serial_link_pkg::credit_t'(`SL_RECV_DEPTH))
    else $error("credit count above receive depth");

endmodule

/* flist.f */
+incdir+design
design/serial_link_pkg.sv
design/serial_link_cfg_regs.sv
design/serial_link_tx.sv
design/serial_link_rx.sv
design/serial_link_top.sv
bench/serial_link_tb.sv

/* run.sh */
#!/bin/sh
# Compile the serial link testbench with Verilator and run it.
# Exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=serial_link_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module serial_link_tb \
  -f flist.f \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./"$BUILD_DIR"/"$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
exit 1
